//--- fm_synth.f
common/fm_pkg.sv
logic/fm_mmr.sv
logic/fm_timers.sv
sound/fm_pg.sv
sound/fm_eg.sv
sound/fm_op.sv
sound/fm_acc.sv
logic/fm_synth.sv
tests/fm_synth_tb.sv

//--- Bender.yml
package:
  name: fm_synth

sources:
  - common/fm_pkg.sv
  - logic/fm_mmr.sv
  - logic/fm_timers.sv
  - sound/fm_pg.sv
  - sound/fm_eg.sv
  - sound/fm_op.sv
  - sound/fm_acc.sv
  - logic/fm_synth.sv
  - target: test
    files:
      - tests/fm_synth_tb.sv

//--- tests/fm_synth_tb.sv
// testbench for fm_synth with CH_NUM 4, one cen per clk except in the FM test
// a slot-level reference model predicts each snd sample from the bus writes
// timer tests count sample pulses between the control write and the flag
`timescale 1ns/1ps
`default_nettype none

module fm_synth_tb import fm_pkg::*;;

    localparam int CH_NUM = 4;
    localparam int SLOTS  = 2 * CH_NUM;

    logic               clk = 1'b0;
    logic               reset = 1'b1;
    logic               cen = 1'b1;
    logic [7:0]         din = '0;
    logic               addr = 1'b0;
    logic               cs_n = 1'b1;
    logic               wr_n = 1'b1;
    logic [7:0]         dout;
    logic               irq_n;
    logic signed [15:0] snd;
    logic               sample;

    fm_synth #(.CH_NUM(CH_NUM)) dut (
        .clk(clk), .reset(reset), .cen(cen), .din(din), .addr(addr),
        .cs_n(cs_n), .wr_n(wr_n), .dout(dout), .irq_n(irq_n), .snd(snd), .sample(sample)
    );

    always #2 clk = ~clk;   // 4 ns period

    int unsigned lcg = 32;        // register stimulus stream
    int unsigned cen_lcg = 32;    // cen gap stream
    string       test_name = "reset";
    int          errors = 0;
    int          err_mark = 0;
    int          tests_pass = 0;
    int          tests_fail = 0;
    logic        cen_random = 1'b0;

    // reference model state
    int          sine_tab [1024];
    logic [7:0]  m_idx;
    logic [3:0]  m_mul [SLOTS];
    logic [5:0]  m_tl [SLOTS];
    logic [3:0]  m_rr [SLOTS];
    logic [7:0]  m_flo [CH_NUM];
    logic [5:0]  m_fhi [CH_NUM];
    logic        m_con [CH_NUM];
    int          m_acc [SLOTS];
    logic        m_kon [SLOTS];
    int          m_eg [SLOTS];
    int          m_slot;
    int          m_mod;
    int          m_sum;
    int          frames [$];
    int          ch;
    int          ph;
    int          inc;
    int          pm;
    int          res;
    int          expected;
    logic        kon;

    function automatic int unsigned lcg_step(input int unsigned state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic int unsigned next_rand();
        lcg = lcg_step(lcg);
        return lcg >> 8;
    endfunction

    // 4095*sin rounded half away from zero
    function automatic int sine_ref(input int p);
        real x;
        x = 4095.0 * $sin(2.0 * 3.14159265358979 * (p + 0.5) / 1024.0);
        if (x >= 0.0)
            return $rtoi(x + 0.5);
        return -$rtoi(0.5 - x);
    endfunction

    task automatic check_value(input string name, input int exp, input int act);
        if (exp != act) begin
            $display("error %s expected %0d actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $finish;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        err_mark  = errors;
    endtask

    task automatic end_test();
        if (errors == err_mark) begin
            $display("test %s passed", test_name);
            tests_pass++;
        end else begin
            $display("test %s failed with %0d errors", test_name, errors - err_mark);
            tests_fail++;
        end
    endtask

    // index write then data write
    task automatic write_reg(input logic [7:0] idx, input logic [7:0] val);
        @(posedge clk);
        cs_n <= 1'b0;
        wr_n <= 1'b0;
        addr <= 1'b0;
        din  <= idx;
        @(posedge clk);
        addr <= 1'b1;
        din  <= val;
        @(posedge clk);
        cs_n <= 1'b1;
        wr_n <= 1'b1;
    endtask

    task automatic wait_samples(input int n);
        int seen;
        int cyc;
        seen = 0;
        for (cyc = 0; cyc < n * SLOTS * 20 + 100 && seen < n; cyc++) begin
            @(posedge clk);
            if (sample)
                seen++;
        end
        if (seen < n)
            abort_run($sformatf("timeout waiting for sample pulses in %s", test_name));
    endtask

    always @(posedge clk) begin
        if (cen_random) begin
            cen_lcg = lcg_step(cen_lcg);
            cen <= ((cen_lcg >> 8) % 3) != 0;   // about one gap in three
        end else begin
            cen <= 1'b1;
        end
    end

    // reference model sees register values from before the edge as the DUT does
    always @(posedge clk) begin
        if (reset) begin
            m_idx  = '0;
            m_slot = 0;
            m_mod  = 0;
            m_sum  = 0;
            frames.delete();
            for (int s = 0; s < SLOTS; s++) begin
                m_mul[s] = '0;
                m_tl[s]  = '0;
                m_rr[s]  = '0;
                m_acc[s] = 0;
                m_kon[s] = 1'b0;
                m_eg[s]  = 64;
            end
            for (int c = 0; c < CH_NUM; c++) begin
                m_flo[c] = '0;
                m_fhi[c] = '0;
                m_con[c] = 1'b0;
            end
        end else begin
            if (sample) begin
                if (frames.size() == 0) begin
                    $display("sample pulse with no frame predicted in %s", test_name);
                    errors++;
                end else begin
                    expected = frames.pop_front();
                    check_value(test_name, expected, int'(snd));
                end
            end
            if (cen) begin
                ch  = m_slot / 2;
                kon = m_fhi[ch][5];
                if (kon && !m_kon[m_slot]) begin   // key-on restart
                    ph = 0;
                    m_acc[m_slot] = 0;
                end else begin
                    ph  = m_acc[m_slot] >> 10;
                    inc = {m_fhi[ch][1:0], m_flo[ch]} << m_fhi[ch][4:2];
                    inc = (m_mul[m_slot] == 0) ? inc / 2 : inc * m_mul[m_slot];
                    m_acc[m_slot] = (m_acc[m_slot] + inc) & 32'hFFFFF;
                end
                m_kon[m_slot] = kon;
                if (kon)
                    m_eg[m_slot] = m_tl[m_slot];
                else if (m_eg[m_slot] + m_rr[m_slot] > 64)
                    m_eg[m_slot] = 64;
                else
                    m_eg[m_slot] = m_eg[m_slot] + m_rr[m_slot];
                pm = ph;
                if (m_slot % 2 == 1 && !m_con[ch])
                    pm = (ph + (m_mod >>> 2)) & 1023;   // phase modulation
                res = (sine_tab[pm] * (64 - m_eg[m_slot])) >>> 6;
                if (m_slot % 2 == 0)
                    m_mod = res;
                if (m_slot % 2 == 1 || m_con[ch])
                    m_sum += res;
                if (m_slot == SLOTS - 1) begin
                    frames.push_back(m_sum);
                    m_sum = 0;
                end
                m_slot = (m_slot + 1) % SLOTS;
            end
            if (!cs_n && !wr_n) begin
                if (!addr)
                    m_idx = din;
                else if (m_idx >= REG_MUL && m_idx < REG_MUL + SLOTS)
                    m_mul[m_idx - REG_MUL] = din[3:0];
                else if (m_idx >= REG_TL && m_idx < REG_TL + SLOTS)
                    m_tl[m_idx - REG_TL] = din[5:0];
                else if (m_idx >= REG_RR && m_idx < REG_RR + SLOTS)
                    m_rr[m_idx - REG_RR] = din[3:0];
                else if (m_idx >= REG_FNUM_LO && m_idx < REG_FNUM_LO + CH_NUM)
                    m_flo[m_idx - REG_FNUM_LO] = din;
                else if (m_idx >= REG_FNUM_HI && m_idx < REG_FNUM_HI + CH_NUM)
                    m_fhi[m_idx - REG_FNUM_HI] = din[5:0];
                else if (m_idx >= REG_CON && m_idx < REG_CON + CH_NUM)
                    m_con[m_idx - REG_CON] = din[0];
            end
        end
    end

    initial begin
        int v;
        int cnt;
        int cyc;
        logic seen;
        logic [5:0] fhi [CH_NUM];
        for (int p = 0; p < 1024; p++)
            sine_tab[p] = sine_ref(p);
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        // 1 idle after reset
        start_test("reset");
        check_value("reset dout", 0, dout);
        check_value("reset irq_n", 1, irq_n);
        wait_samples(4);
        check_value("reset snd", 0, snd);
        end_test();

        // 2 timer A overflow count in frames
        start_test("timer_a");
        v = next_rand() % 256;
        write_reg(REG_TIMER_A, 8'(v));
        write_reg(REG_TIMER_CTL, 8'h01);
        cnt  = 0;
        seen = 1'b0;
        for (cyc = 0; cyc < 270 * SLOTS * 2 && !seen; cyc++) begin
            @(posedge clk);
            if (sample) begin
                cnt++;
                seen = dout[6];    // flag frame's own pulse closes the count
            end
        end
        if (!seen)
            abort_run("timer A flag never set");
        if (cnt != 256 - v && cnt != 257 - v)
            check_value("timer_a frames", 256 - v, cnt);
        check_value("timer_a irq_n", 0, irq_n);
        check_value("timer_a dout", 8'hC0, dout);   // irq active and flag A
        write_reg(REG_TIMER_CTL, 8'h80);
        repeat (2) @(posedge clk);
        check_value("timer_a irq_n after clear", 1, irq_n);
        write_reg(REG_TIMER_CTL, 8'h00);
        end_test();

        // 3 timer B masked then unmasked
        start_test("timer_b");
        v = next_rand() % 256;
        write_reg(REG_TIMER_B, 8'(v));
        write_reg(REG_TIMER_CTL, 8'h22);
        cnt = 0;
        for (cyc = 0; cyc < 1200 * SLOTS && cnt < 1100; cyc++) begin
            @(posedge clk);
            if (sample)
                cnt++;
            if (!irq_n) begin
                $display("interrupt raised while timer B masked");
                errors++;
                cnt = 1100;
            end
        end
        if (cnt < 1100)
            abort_run("timeout waiting through masked timer B");
        write_reg(REG_TIMER_CTL, 8'h02);
        cnt  = 0;
        seen = 1'b0;
        for (cyc = 0; cyc < (4 * (256 - v) + 8) * SLOTS && !seen; cyc++) begin
            @(posedge clk);
            if (sample)
                cnt++;
            seen = dout[5];
        end
        if (!seen || cnt > 4 * (256 - v) + 4) begin
            $display("timer B flag late or missing after %0d frames", cnt);
            errors++;
        end else begin
            check_value("timer_b dout", 8'hA0, dout);   // irq active and flag B
        end
        write_reg(REG_TIMER_CTL, 8'h80);
        write_reg(REG_TIMER_CTL, 8'h00);
        end_test();

        // 4 additive tone on channel 0
        start_test("additive");
        write_reg(REG_CON, 8'h01);
        for (int s = 0; s < 2; s++) begin
            write_reg(REG_MUL + 8'(s), 8'(next_rand() % 16));
            write_reg(REG_TL + 8'(s), 8'(next_rand() % 64));
        end
        write_reg(REG_FNUM_LO, 8'(next_rand()));
        fhi[0] = {1'b1, 3'(next_rand()), 2'(next_rand())};
        write_reg(REG_FNUM_HI, {2'b00, fhi[0]});
        wait_samples(2);
        wait_samples(20);
        end_test();

        // 5 FM on every channel, cen with gaps
        start_test("fm_random_cen");
        cen_random <= 1'b1;
        for (int c = 0; c < CH_NUM; c++) begin
            write_reg(REG_CON + 8'(c), 8'h00);
            for (int s = 2 * c; s < 2 * c + 2; s++) begin
                write_reg(REG_MUL + 8'(s), 8'(next_rand() % 16));
                write_reg(REG_TL + 8'(s), 8'(next_rand() % 64));
            end
            write_reg(REG_FNUM_LO + 8'(c), 8'(next_rand()));
            fhi[c] = {1'b1, 3'(next_rand()), 2'(next_rand())};
            write_reg(REG_FNUM_HI + 8'(c), {2'b00, fhi[c]});
        end
        wait_samples(2);
        wait_samples(50);
        cen_random <= 1'b0;
        end_test();

        // 6 key off and release to silence
        start_test("release");
        for (int s = 0; s < SLOTS; s++)
            write_reg(REG_RR + 8'(s), 8'd8);
        for (int c = 0; c < CH_NUM; c++)
            write_reg(REG_FNUM_HI + 8'(c), {3'b000, fhi[c][4:0]});
        cnt = 0;
        while (cnt < 9 && snd != 0) begin    // frame in flight plus 8 release steps
            wait_samples(1);
            cnt++;
        end
        if (snd != 0)
            check_value("release snd", 0, snd);
        wait_samples(3);
        end_test();

        $display("tests passed %0d failed %0d errors %0d", tests_pass, tests_fail, errors);
        if (errors == 0 && tests_fail == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/fm_synth.sv
// FM generator top: CPU register file, timers and the multiplexed voice path
// cen is the slot enable, one slot per clk with cen high, 2*CH_NUM slots per frame
// snd is held between sample pulses; CH_NUM above 4 can overflow snd
`timescale 1ns/1ps
`default_nettype none

module fm_synth import fm_pkg::*; #(
    parameter int CH_NUM = 4
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    cen,
    input  logic [7:0]              din,
    input  logic                    addr,
    input  logic                    cs_n,
    input  logic                    wr_n,
    output logic [7:0]              dout,
    output logic                    irq_n,
    output logic signed [SND_W-1:0] snd,
    output logic                    sample
);

    localparam int SLOT_W = $clog2(2 * CH_NUM);

    logic [SLOT_W-1:0] slot;
    logic              frame_end;
    logic [7:0]        value_a;
    logic [7:0]        value_b;
    logic              load_a;
    logic              load_b;
    logic              mask_a;
    logic              mask_b;
    logic              clr_flags;
    logic              flag_a;
    logic              flag_b;
    logic [9:0]        fnum;
    logic [2:0]        block;
    logic [3:0]        mul;
    logic [5:0]        tl;
    logic [3:0]        rr;
    logic              keyon;
    logic              con;
    logic [9:0]        phase;          // one slot behind
    logic [ATT_W-1:0]  atten;          // aligned with phase
    logic signed [13:0] op_result;     // two slots behind
    logic [SLOT_W-1:0] op_slot;

    assign dout = {~irq_n, flag_a, flag_b, 5'd0};   // status byte

    fm_mmr #(.CH_NUM(CH_NUM)) u_mmr (
        .clk       (clk),
        .reset     (reset),
        .cen       (cen),
        .din       (din),
        .addr      (addr),
        .cs_n      (cs_n),
        .wr_n      (wr_n),
        .slot      (slot),
        .frame_end (frame_end),
        .value_a   (value_a),
        .value_b   (value_b),
        .load_a    (load_a),
        .load_b    (load_b),
        .mask_a    (mask_a),
        .mask_b    (mask_b),
        .clr_flags (clr_flags),
        .fnum      (fnum),
        .block     (block),
        .mul       (mul),
        .tl        (tl),
        .rr        (rr),
        .keyon     (keyon),
        .con       (con)
    );

    fm_timers u_timers (
        .clk       (clk),
        .reset     (reset),
        .cen       (cen),
        .frame_end (frame_end),
        .value_a   (value_a),
        .value_b   (value_b),
        .load_a    (load_a),
        .load_b    (load_b),
        .mask_a    (mask_a),
        .mask_b    (mask_b),
        .clr_flags (clr_flags),
        .flag_a    (flag_a),
        .flag_b    (flag_b),
        .irq_n     (irq_n)
    );

    fm_pg #(.CH_NUM(CH_NUM)) u_pg (
        .clk   (clk),
        .reset (reset),
        .cen   (cen),
        .slot  (slot),
        .fnum  (fnum),
        .block (block),
        .mul   (mul),
        .keyon (keyon),
        .phase (phase)
    );

    fm_eg #(.CH_NUM(CH_NUM)) u_eg (
        .clk   (clk),
        .reset (reset),
        .cen   (cen),
        .slot  (slot),
        .tl    (tl),
        .rr    (rr),
        .keyon (keyon),
        .atten (atten)
    );

    fm_op #(.CH_NUM(CH_NUM)) u_op (
        .clk       (clk),
        .reset     (reset),
        .cen       (cen),
        .slot      (slot),
        .con       (con),
        .phase     (phase),
        .atten     (atten),
        .op_result (op_result),
        .op_slot   (op_slot)
    );

    fm_acc #(.CH_NUM(CH_NUM)) u_acc (
        .clk       (clk),
        .reset     (reset),
        .cen       (cen),
        .con       (con),
        .op_result (op_result),
        .op_slot   (op_slot),
        .snd       (snd),
        .sample    (sample)
    );

endmodule

`default_nettype wire

//--- sound/fm_acc.sv
// sums the audible operators of a frame into one sample
// carriers always count, modulators only on channels with con set
// no saturation, fine up to CH_NUM 4
`timescale 1ns/1ps
`default_nettype none

module fm_acc import fm_pkg::*; #(
    parameter  int CH_NUM = 4,
    localparam int SLOT_W = $clog2(2 * CH_NUM)
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    cen,
    input  logic                    con,
    input  logic signed [13:0]      op_result,
    input  logic [SLOT_W-1:0]       op_slot,
    output logic signed [SND_W-1:0] snd,
    output logic                    sample
);

    localparam int SLOTS = 2 * CH_NUM;

    logic                    con_a;   // two stages to line up with op_slot
    logic                    con_b;
    logic                    take;
    logic signed [SND_W-1:0] term;
    logic signed [SND_W-1:0] sum;

    assign take = slot_is_carrier(int'(op_slot)) || con_b;
    assign term = take ? SND_W'(op_result) : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            con_a  <= 1'b0;
            con_b  <= 1'b0;
            sum    <= '0;
            snd    <= '0;
            sample <= 1'b0;
        end else begin
            sample <= 1'b0;
            if (cen) begin
                con_a <= con;
                con_b <= con_a;
                if (op_slot == SLOT_W'(SLOTS - 1)) begin
                    snd    <= sum + term;   // frame complete
                    sum    <= '0;
                    sample <= 1'b1;
                end else begin
                    sum <= sum + term;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- sound/fm_op.sv
// operator: sine lookup, phase modulation and envelope scaling
// the carrier on the next slot uses the modulator output held here
// with con set the carrier runs unmodulated and the modulator is heard too
`timescale 1ns/1ps
`default_nettype none

module fm_op import fm_pkg::*; #(
    parameter  int CH_NUM = 4,
    localparam int SLOT_W = $clog2(2 * CH_NUM)
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               cen,
    input  logic [SLOT_W-1:0]  slot,
    input  logic               con,
    input  logic [9:0]         phase,
    input  logic [ATT_W-1:0]   atten,
    output logic signed [13:0] op_result,
    output logic [SLOT_W-1:0]  op_slot
);

    wire signed [SINE_W-1:0] sine_rom [1024];

    for (genvar i = 0; i < 1024; i++) begin : g_rom
        assign sine_rom[i] = sine_value(i);
    end

    logic [SLOT_W-1:0]        slot_d;     // slot of phase and atten
    logic                     con_d;
    logic signed [13:0]       mod_hold;   // last modulator output
    logic                     carrier;
    logic [9:0]               pm;
    logic signed [SINE_W-1:0] sine;
    logic signed [7:0]        gain;       // 0..64
    logic signed [SINE_W+7:0] prod;
    logic signed [13:0]       result;

    assign carrier = slot_is_carrier(int'(slot_d));
    assign pm      = (carrier && !con_d) ? phase + 10'(mod_hold >>> 2) : phase;  // wraps mod 1024
    assign sine    = sine_rom[pm];
    assign gain    = {1'b0, ATT_W'(ATT_W'(64) - atten)};
    assign prod    = sine * gain;
    assign result  = 14'(prod >>> 6);     // floor toward minus infinity

    always_ff @(posedge clk) begin
        if (reset) begin
            slot_d    <= '0;
            con_d     <= 1'b0;
            mod_hold  <= '0;
            op_result <= '0;
            op_slot   <= '0;
        end else if (cen) begin
            slot_d    <= slot;
            con_d     <= con;
            op_result <= result;
            op_slot   <= slot_d;
            if (!carrier)
                mod_hold <= result;
        end
    end

endmodule

`default_nettype wire

//--- sound/fm_eg.sv
// linear envelope, attenuation in steps of 1/64 of full scale
// key on holds the slot at tl, key off climbs by rr per frame up to 64
// same one-slot latency as the phase generator
`timescale 1ns/1ps
`default_nettype none

module fm_eg import fm_pkg::*; #(
    parameter  int CH_NUM = 4,
    localparam int SLOT_W = $clog2(2 * CH_NUM)
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              cen,
    input  logic [SLOT_W-1:0] slot,
    input  logic [5:0]        tl,
    input  logic [3:0]        rr,
    input  logic              keyon,
    output logic [ATT_W-1:0]  atten
);

    localparam int SLOTS = 2 * CH_NUM;
    localparam logic [ATT_W-1:0] SILENT = ATT_W'(64);

    logic [ATT_W-1:0] eg_r [SLOTS];
    logic [ATT_W-1:0] rel;            // 64 + 15 still fits
    logic [ATT_W-1:0] next;

    assign rel  = eg_r[slot] + ATT_W'(rr);
    assign next = keyon ? ATT_W'(tl) : ((rel > SILENT) ? SILENT : rel);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < SLOTS; s++)
                eg_r[s] <= SILENT;
            atten <= SILENT;
        end else if (cen) begin
            eg_r[slot] <= next;
            atten      <= next;       // new value goes straight out
        end
    end

endmodule

`default_nettype wire

//--- sound/fm_pg.sv
// phase generator, one accumulator per slot, stepped once per frame
// step is (fnum << block) * mul, mul 0 gives half a step
// a key-on rising edge restarts the slot at phase 0
`timescale 1ns/1ps
`default_nettype none

module fm_pg import fm_pkg::*; #(
    parameter  int CH_NUM = 4,
    localparam int SLOT_W = $clog2(2 * CH_NUM)
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              cen,
    input  logic [SLOT_W-1:0] slot,
    input  logic [9:0]        fnum,
    input  logic [2:0]        block,
    input  logic [3:0]        mul,
    input  logic              keyon,
    output logic [9:0]        phase
);

    localparam int SLOTS = 2 * CH_NUM;

    logic [PHASE_W-1:0] acc [SLOTS];
    logic [SLOTS-1:0]   kon_d;        // keyon seen last frame
    logic [PHASE_W-1:0] base;
    logic [PHASE_W-1:0] inc;
    logic               kon_edge;

    assign base     = PHASE_W'(fnum) << block;   // at most 17 bits
    assign inc      = (mul == 4'd0) ? base >> 1 : base * mul;
    assign kon_edge = keyon && !kon_d[slot];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < SLOTS; s++)
                acc[s] <= '0;
            kon_d <= '0;
            phase <= '0;
        end else if (cen) begin
            kon_d[slot] <= keyon;
            if (kon_edge) begin
                acc[slot] <= '0;
                phase     <= '0;
            end else begin
                phase     <= acc[slot][PHASE_W-1 -: 10];  // value before the add
                acc[slot] <= acc[slot] + inc;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/fm_timers.sv
// timers A and B, both 8-bit up counters that overflow past 255
// A ticks once per frame, B once every four frames, only while loaded
// a masked timer still reloads on overflow but leaves its flag alone
`timescale 1ns/1ps
`default_nettype none

module fm_timers (
    input  logic       clk,
    input  logic       reset,
    input  logic       cen,
    input  logic       frame_end,
    input  logic [7:0] value_a,
    input  logic [7:0] value_b,
    input  logic       load_a,
    input  logic       load_b,
    input  logic       mask_a,
    input  logic       mask_b,
    input  logic       clr_flags,
    output logic       flag_a,
    output logic       flag_b,
    output logic       irq_n
);

    // index 0 is timer A, index 1 is timer B
    logic [7:0] cnt [2];
    logic [7:0] value [2];
    logic [1:0] load;
    logic [1:0] load_d;               // for load rising edge
    logic [1:0] mask;
    logic [1:0] tick;
    logic [1:0] flag;
    logic [1:0] div_b;                // frame prescaler for B
    logic       frame_tick;

    assign value[0]   = value_a;
    assign value[1]   = value_b;
    assign load       = {load_b, load_a};
    assign mask       = {mask_b, mask_a};
    assign frame_tick = cen && frame_end;
    assign tick       = {frame_tick && (div_b == 2'd3), frame_tick};

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt[0] <= '0;
            cnt[1] <= '0;
            load_d <= '0;
            flag   <= '0;
            div_b  <= '0;
        end else begin
            load_d <= load;
            if (frame_tick)
                div_b <= div_b + 2'd1;    // free running
            for (int t = 0; t < 2; t++) begin
                if (load[t] && !load_d[t]) begin
                    cnt[t] <= value[t];     // load wins over a tick
                end else if (load[t] && tick[t]) begin
                    if (cnt[t] == 8'hFF) begin
                        cnt[t] <= value[t];
                        if (!mask[t])
                            flag[t] <= 1'b1;
                    end else begin
                        cnt[t] <= cnt[t] + 8'd1;
                    end
                end
            end
            if (clr_flags)
                flag <= '0;               // clear beats a same-clk overflow
        end
    end

    assign flag_a = flag[0];
    assign flag_b = flag[1];
    assign irq_n  = ~|flag;           // low while any flag set

endmodule

`default_nettype wire

//--- logic/fm_mmr.sv
// CPU bus decode, register storage and slot sequencing
// addr 0 latches the register index, addr 1 writes the indexed register
// a control write with bit 7 set only clears the flags, other bits are kept
`timescale 1ns/1ps
`default_nettype none

module fm_mmr import fm_pkg::*; #(
    parameter  int CH_NUM = 4,
    localparam int SLOT_W = $clog2(2 * CH_NUM)
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              cen,
    input  logic [7:0]        din,
    input  logic              addr,
    input  logic              cs_n,
    input  logic              wr_n,
    output logic [SLOT_W-1:0] slot,
    output logic              frame_end,
    output logic [7:0]        value_a,
    output logic [7:0]        value_b,
    output logic              load_a,
    output logic              load_b,
    output logic              mask_a,
    output logic              mask_b,
    output logic              clr_flags,
    output logic [9:0]        fnum,
    output logic [2:0]        block,
    output logic [3:0]        mul,
    output logic [5:0]        tl,
    output logic [3:0]        rr,
    output logic              keyon,
    output logic              con
);

    localparam int SLOTS = 2 * CH_NUM;
    localparam int CH_W  = $clog2(CH_NUM);

    logic            write;
    logic [7:0]      idx;             // index latch
    logic [3:0]      mul_r [SLOTS];
    logic [5:0]      tl_r  [SLOTS];
    logic [3:0]      rr_r  [SLOTS];
    logic [7:0]      flo_r [CH_NUM];
    logic [5:0]      fhi_r [CH_NUM];  // key on, block, fnum msbs
    logic            con_r [CH_NUM];
    logic [CH_W-1:0] ch;

    assign write = !cs_n && !wr_n;    // every low-strobe clk is a write

    always_ff @(posedge clk) begin
        if (reset) begin
            idx       <= '0;
            value_a   <= '0;
            value_b   <= '0;
            load_a    <= 1'b0;
            load_b    <= 1'b0;
            mask_a    <= 1'b0;
            mask_b    <= 1'b0;
            clr_flags <= 1'b0;
            for (int s = 0; s < SLOTS; s++) begin
                mul_r[s] <= '0;
                tl_r[s]  <= '0;
                rr_r[s]  <= '0;
            end
            for (int c = 0; c < CH_NUM; c++) begin
                flo_r[c] <= '0;
                fhi_r[c] <= '0;
                con_r[c] <= 1'b0;
            end
        end else begin
            clr_flags <= 1'b0;        // single clk pulse
            if (write && !addr)
                idx <= din;
            if (write && addr) begin
                if (idx == REG_TIMER_A)
                    value_a <= din;
                if (idx == REG_TIMER_B)
                    value_b <= din;
                if (idx == REG_TIMER_CTL) begin
                    if (din[7]) begin
                        clr_flags <= 1'b1;
                    end else begin
                        load_a <= din[0];
                        load_b <= din[1];
                        mask_b <= din[5];
                        mask_a <= din[6];
                    end
                end
                for (int s = 0; s < SLOTS; s++) begin
                    if (idx == REG_MUL + s)
                        mul_r[s] <= din[3:0];
                    if (idx == REG_TL + s)
                        tl_r[s] <= din[5:0];
                    if (idx == REG_RR + s)
                        rr_r[s] <= din[3:0];
                end
                for (int c = 0; c < CH_NUM; c++) begin
                    if (idx == REG_FNUM_LO + c)
                        flo_r[c] <= din;
                    if (idx == REG_FNUM_HI + c)
                        fhi_r[c] <= din[5:0];
                    if (idx == REG_CON + c)
                        con_r[c] <= din[0];
                end
            end
        end
    end

    // slot counter, one slot per cen
    always_ff @(posedge clk) begin
        if (reset)
            slot <= '0;
        else if (cen)
            slot <= (slot == SLOT_W'(SLOTS - 1)) ? '0 : slot + 1'b1;
    end

    assign frame_end = cen && (slot == SLOT_W'(SLOTS - 1));

    // fields for the slot being processed now
    assign ch    = CH_W'(slot_channel(int'(slot)));
    assign mul   = mul_r[slot];
    assign tl    = tl_r[slot];
    assign rr    = rr_r[slot];
    assign fnum  = {fhi_r[ch][1:0], flo_r[ch]};
    assign block = fhi_r[ch][4:2];
    assign keyon = fhi_r[ch][5];
    assign con   = con_r[ch];

endmodule

`default_nettype wire

//--- common/fm_pkg.sv
// shared widths, register map and slot helpers for the FM generator
// sine_value uses real math and is meant for elaboration-time ROM fill only
// slot s belongs to channel s/2, even slots modulate, odd slots are carriers
`default_nettype none

package fm_pkg;

    localparam int PHASE_W = 20;   // top 10 bits index the sine
    localparam int SINE_W  = 13;   // signed, +-4095
    localparam int ATT_W   = 7;    // 0..64, 64 is silent
    localparam int SND_W   = 16;   // no overflow only while CH_NUM <= 4

    // timer registers
    localparam logic [7:0] REG_TIMER_A   = 8'h02;
    localparam logic [7:0] REG_TIMER_B   = 8'h03;
    localparam logic [7:0] REG_TIMER_CTL = 8'h04;

    // per-slot bases, index is base + slot
    localparam logic [7:0] REG_MUL = 8'h20;   // [3:0] multiplier
    localparam logic [7:0] REG_TL  = 8'h40;   // [5:0] total level
    localparam logic [7:0] REG_RR  = 8'h80;   // [3:0] release rate

    // per-channel bases, index is base + channel
    localparam logic [7:0] REG_FNUM_LO = 8'hA0;  // fnum [7:0]
    localparam logic [7:0] REG_FNUM_HI = 8'hB0;  // [5] key on, [4:2] block, [1:0] fnum
    localparam logic [7:0] REG_CON     = 8'hC0;  // [0] additive connection

    // rounded 4095*sin(2*pi*(p+0.5)/1024)
    function automatic logic signed [SINE_W-1:0] sine_value(input int p);
        real x;
        x = 4095.0 * $sin(2.0 * 3.14159265358979 * (real'(p) + 0.5) / 1024.0);
        if (x >= 0.0)
            return SINE_W'($rtoi(x + 0.5));
        return -SINE_W'($rtoi(0.5 - x));  // round half away from zero
    endfunction

    function automatic logic slot_is_carrier(input int s);
        return s[0];
    endfunction

    function automatic int slot_channel(input int s);
        return s / 2;
    endfunction

endpackage

`default_nettype wire
